/* common/spi_defines.svh */
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// ========================================
// register map constants
// ========================================

// value returned at address 0.
`define SPI_DEVICE_ID 8'hA5

// register address width for 16 locations.
`define REG_ADDR_W 4

// ========================================
// stream flow control
// ========================================

// credits held by the stream port out of reset.
`define STREAM_CREDITS 4

// credit counter width as shown in status bits 7:4.
`define CREDIT_W 4

`endif

/* common/spi_link_pkg.sv */
package spi_link_pkg;

	// ========================================
	// spi byte link types
	// ========================================

	// one msb-first byte on mosi or miso.
	typedef logic [7:0] spi_byte_t;

	// bit position inside the byte being shifted.
	typedef logic [2:0] bit_idx_t;

	// a full byte is seen when the count wraps from 7.
	localparam bit_idx_t LAST_BIT = 3'd7;

endpackage

/* common/reg_map_pkg.sv */
`include "spi_defines.svh"

package reg_map_pkg;

	// ========================================
	// register side types
	// ========================================

	typedef logic [`REG_ADDR_W-1:0] reg_addr_t; // register address.
	typedef logic [7:0] reg_data_t; // register value.
	typedef logic [`CREDIT_W-1:0] credit_cnt_t; // stream credit count.

	// command decoder states.
	typedef enum logic [1:0] {
		IDLE, // cs high and nothing going on.
		CMD, // waiting for the command byte.
		WRITE, // following bytes go to the register.
		READ // following bytes shift register data out.
	} dec_state_t;

	// ========================================
	// register map
	// ========================================

	localparam reg_addr_t ADDR_ID = reg_addr_t'(0); // read-only id.
	localparam reg_addr_t ADDR_SCRATCH = reg_addr_t'(1); // scratch.
	localparam reg_addr_t ADDR_CTRL = reg_addr_t'(2); // drives ctrl output.
	localparam reg_addr_t ADDR_STATUS = reg_addr_t'(3); // credits and overflow.
	localparam reg_addr_t ADDR_STREAM = reg_addr_t'(4); // write-only stream data.
	localparam reg_addr_t ADDR_STATUS_IN = reg_addr_t'(5); // status_in sample.

endpackage

/* spi_device/spi_device_transceiver.sv */
`timescale 1ns/1ps

// oversampling spi device transceiver, mode 0, msb first.
// no clock-capable pin for sck; clk must be 8x sck or faster.
module spi_device_transceiver (
	input logic clk,
	input logic reset,

	input logic spi_sck,
	input logic spi_mosi,
	input logic spi_cs_n,
	output logic spi_miso,

	input spi_link_pkg::spi_byte_t tx_data,
	input logic tx_data_valid,
	output spi_link_pkg::spi_byte_t rx_data,
	output logic rx_data_valid,
	output logic cs_falling,
	output logic cs_n_sync
);
	import spi_link_pkg::*;

	// ========================================
	// input synchronizers
	// ========================================

	// pins travel together as {cs_n, sck, mosi}.
	logic [2:0] sync_q1;
	logic [2:0] sync_q2;
	logic [2:0] sync_q3;

	logic sck_sync;
	logic mosi_sync;
	logic sck_prev; // previous synchronized sck.
	logic cs_n_prev; // previous synchronized cs_n.
	logic sck_rising;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q1 <= 3'b100; // cs idles high.
			sync_q2 <= 3'b100;
			sync_q3 <= 3'b100;
			sck_prev <= 1'b0;
			cs_n_prev <= 1'b1;
		end else begin
			sync_q1 <= {spi_cs_n, spi_sck, spi_mosi};
			sync_q2 <= sync_q1;
			sync_q3 <= sync_q2;
			sck_prev <= sck_sync; // for edge detect.
			cs_n_prev <= cs_n_sync;
		end
	end

	assign cs_n_sync = sync_q3[2];
	assign sck_sync = sync_q3[1];
	assign mosi_sync = sync_q3[0];

	// ========================================
	// edge detection
	// ========================================

	assign cs_falling = cs_n_prev && !cs_n_sync; // start of transaction.

	// sck edges only count while selected.
	assign sck_rising = !sck_prev && sck_sync && !cs_n_sync;

	// ========================================
	// shift registers
	// ========================================

	bit_idx_t bit_cnt; // bits taken so far in this byte.
	spi_byte_t rx_shift; // receive shift register.
	spi_byte_t tx_shift; // transmit shift register with msb on miso.

	assign spi_miso = tx_shift[7];

	// mosi shifts in on each sampled sck rise.
	always_ff @(posedge clk) begin
		if (sck_rising) begin
			rx_shift <= {rx_shift[6:0], mosi_sync};
			if (bit_cnt == LAST_BIT)
				rx_data <= {rx_shift[6:0], mosi_sync}; // complete byte.
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= '0;
			tx_shift <= '0; // miso low.
			rx_data_valid <= 1'b0;
		end else begin
			rx_data_valid <= 1'b0;

			if (cs_falling) begin
				// new transaction drops any partial byte.
				bit_cnt <= '0;
				tx_shift <= '0;
			end else if (sck_rising) begin
				bit_cnt <= bit_cnt + 1'b1; // wraps after bit 7.
				tx_shift <= {tx_shift[6:0], 1'b0}; // next bit onto miso.
				if (bit_cnt == LAST_BIT)
					rx_data_valid <= 1'b1;
			end

			// reply byte from the decoder.
			if (tx_data_valid)
				tx_shift <= tx_data;
		end
	end

	// ========================================
	// assertions
	// ========================================

	// a byte only completes inside a transaction.
	assert property (@(posedge clk) disable iff (reset)
		rx_data_valid |-> !cs_n_sync)
		else $error("rx_data_valid while cs_n_sync high");

endmodule

/* spi_device/spi_command_decoder.sv */
`timescale 1ns/1ps

`include "spi_defines.svh"

// spi command decoder.
// byte 0 is the command with bit 7 set for read and the address in bits 3:0.
// later bytes are written to, or read from, the auto-incremented address.
module spi_command_decoder (
	input logic clk,
	input logic reset,

	// byte link from the transceiver.
	input spi_link_pkg::spi_byte_t rx_data,
	input logic rx_data_valid,
	input logic cs_falling,
	input logic cs_n_sync,
	output spi_link_pkg::spi_byte_t tx_data,
	output logic tx_data_valid,

	// register bus.
	output reg_map_pkg::reg_addr_t reg_addr,
	output reg_map_pkg::reg_data_t reg_wdata,
	output logic reg_we,
	input reg_map_pkg::reg_data_t reg_rdata
);
	import reg_map_pkg::*;

	// ========================================
	// address stepping
	// ========================================

	dec_state_t state;
	reg_addr_t next_addr;

	// the stream register stays put so a burst feeds the stream.
	always_comb begin
		if (reg_addr == ADDR_STREAM)
			next_addr = reg_addr;
		else
			next_addr = reg_addr + 1'b1;
	end

	// reply follows the address in the tx_data_valid cycle.
	assign tx_data = reg_rdata;

	// ========================================
	// decoder fsm
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			reg_addr <= '0;
			reg_we <= 1'b0;
			tx_data_valid <= 1'b0;
		end else begin
			reg_we <= 1'b0; // single-cycle pulses.
			tx_data_valid <= 1'b0;

			// step past a location once it has been written.
			if (reg_we)
				reg_addr <= next_addr;

			if (cs_falling) begin
				state <= CMD; // new transaction.
			end else begin
				case (state)
					IDLE: begin
						// wait for cs to fall.
					end

					CMD: begin
						if (cs_n_sync) begin
							state <= IDLE; // aborted before a command.
						end else if (rx_data_valid) begin
							reg_addr <= rx_data[`REG_ADDR_W-1:0];
							if (rx_data[7]) begin
								state <= READ;
								tx_data_valid <= 1'b1; // first reply byte.
							end else begin
								state <= WRITE;
							end
						end
					end

					WRITE: begin
						if (cs_n_sync)
							state <= IDLE;
						else if (rx_data_valid)
							reg_we <= 1'b1; // address steps after the pulse.
					end

					READ: begin
						if (cs_n_sync) begin
							state <= IDLE;
						end else if (rx_data_valid) begin
							reg_addr <= next_addr;
							tx_data_valid <= 1'b1; // reply for the next byte.
						end
					end

					default: state <= IDLE;
				endcase
			end
		end
	end

	// write data captured with each byte.
	always_ff @(posedge clk) begin
		if (rx_data_valid)
			reg_wdata <= rx_data;
	end

	// ========================================
	// assertions
	// ========================================

	// a transaction writes or reads but never both.
	assert property (@(posedge clk) disable iff (reset)
		!(reg_we && tx_data_valid))
		else $error("reg_we and tx_data_valid together");

endmodule

/* hw/reg_bank.sv */
`timescale 1ns/1ps

`include "spi_defines.svh"

// register bank behind the spi decoder.
// holds scratch and ctrl, turns stream and status writes into pulses.
module reg_bank (
	input logic clk,
	input logic reset,

	input reg_map_pkg::reg_addr_t reg_addr,
	input reg_map_pkg::reg_data_t reg_wdata,
	input logic reg_we,
	output reg_map_pkg::reg_data_t reg_rdata,

	input reg_map_pkg::reg_data_t status_in,
	output reg_map_pkg::reg_data_t ctrl,

	// stream port side.
	input reg_map_pkg::credit_cnt_t credits,
	input logic overflow,
	output logic push,
	output reg_map_pkg::reg_data_t push_data,
	output logic clear_overflow
);
	import reg_map_pkg::*;

	reg_data_t scratch;
	reg_data_t status; // credits in 7:4, overflow in bit 0.

	// ========================================
	// writable registers
	// ========================================

	always_ff @(posedge clk) begin
		if (reset) begin
			scratch <= '0;
			ctrl <= '0;
		end else if (reg_we) begin
			case (reg_addr)
				ADDR_SCRATCH: scratch <= reg_wdata;
				ADDR_CTRL: ctrl <= reg_wdata;
				default: ; // others handled below or ignored.
			endcase
		end
	end

	// ========================================
	// side-effect pulses
	// ========================================

	assign push = reg_we && (reg_addr == ADDR_STREAM);
	assign push_data = reg_wdata;

	// write-one-to-clear on overflow.
	assign clear_overflow = reg_we && (reg_addr == ADDR_STATUS) && reg_wdata[0];

	// ========================================
	// read decode
	// ========================================

	assign status = {credits, 3'b000, overflow};

	always_comb begin
		case (reg_addr)
			ADDR_ID: reg_rdata = `SPI_DEVICE_ID;
			ADDR_SCRATCH: reg_rdata = scratch;
			ADDR_CTRL: reg_rdata = ctrl;
			ADDR_STATUS: reg_rdata = status;
			ADDR_STATUS_IN: reg_rdata = status_in; // live sample.
			default: reg_rdata = '0; // stream is write-only.
		endcase
	end

endmodule

/* hw/stream_credit_port.sv */
`timescale 1ns/1ps

`include "spi_defines.svh"

// credit-flow byte stream output.
// one credit per byte sent and returned by stream_credit pulses.
module stream_credit_port (
	input logic clk,
	input logic reset,

	input logic push,
	input reg_map_pkg::reg_data_t push_data,
	input logic clear_overflow,
	input logic stream_credit,

	output logic stream_valid,
	output spi_link_pkg::spi_byte_t stream_data,
	output reg_map_pkg::credit_cnt_t credits,
	output logic overflow
);
	import reg_map_pkg::*;

	localparam credit_cnt_t MAX_CREDITS = credit_cnt_t'(`STREAM_CREDITS);

	logic take; // push that has a credit to spend.
	logic give; // credit return that is counted.

	assign take = push && (credits != '0);
	// a full counter only takes a credit back if one is spent alongside.
	assign give = stream_credit && ((credits != MAX_CREDITS) || take);

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= MAX_CREDITS;
			overflow <= 1'b0;
			stream_valid <= 1'b0;
		end else begin
			stream_valid <= take; // one cycle after the push.

			if (take && !give)
				credits <= credits - 1'b1;
			else if (give && !take)
				credits <= credits + 1'b1;

			// sticky until cleared; a dropped byte wins.
			if (push && (credits == '0))
				overflow <= 1'b1;
			else if (clear_overflow)
				overflow <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			stream_data <= push_data;
	end

	// ========================================
	// assertions
	// ========================================

	assert property (@(posedge clk) disable iff (reset)
		credits <= MAX_CREDITS)
		else $error("credits above initial value");

	// every byte out was paid for with a credit.
	assert property (@(posedge clk) disable iff (reset)
		stream_valid |-> ($past(credits) != '0))
		else $error("stream_valid with no credits");

endmodule

/* hw/spi_reg_bridge_top.sv */
`timescale 1ns/1ps

// top level of the spi device register bridge.
module spi_reg_bridge_top (
	input logic clk,
	input logic reset,

	input logic spi_sck,
	input logic spi_mosi,
	input logic spi_cs_n,
	output logic spi_miso,

	input reg_map_pkg::reg_data_t status_in,
	output reg_map_pkg::reg_data_t ctrl,

	input logic stream_credit,
	output logic stream_valid,
	output spi_link_pkg::spi_byte_t stream_data
);
	import spi_link_pkg::*;
	import reg_map_pkg::*;

	// ========================================
	// internal wiring
	// ========================================

	spi_byte_t rx_data; // transceiver to decoder.
	logic rx_data_valid;
	logic cs_falling;
	logic cs_n_sync;
	spi_byte_t tx_data; // decoder to transceiver.
	logic tx_data_valid;

	reg_addr_t reg_addr; // register bus.
	reg_data_t reg_wdata;
	reg_data_t reg_rdata;
	logic reg_we;

	logic push; // reg bank to stream port.
	reg_data_t push_data;
	logic clear_overflow;
	credit_cnt_t credits;
	logic overflow;

	spi_device_transceiver xcvr_i (
		.clk(clk), .reset(reset),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n),
		.spi_miso(spi_miso),
		.tx_data(tx_data), .tx_data_valid(tx_data_valid),
		.rx_data(rx_data), .rx_data_valid(rx_data_valid),
		.cs_falling(cs_falling), .cs_n_sync(cs_n_sync)
	);

	spi_command_decoder dec_i (
		.clk(clk), .reset(reset),
		.rx_data(rx_data), .rx_data_valid(rx_data_valid),
		.cs_falling(cs_falling), .cs_n_sync(cs_n_sync),
		.tx_data(tx_data), .tx_data_valid(tx_data_valid),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we),
		.reg_rdata(reg_rdata)
	);

	reg_bank regs_i (
		.clk(clk), .reset(reset),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_we(reg_we),
		.reg_rdata(reg_rdata),
		.status_in(status_in), .ctrl(ctrl),
		.credits(credits), .overflow(overflow),
		.push(push), .push_data(push_data), .clear_overflow(clear_overflow)
	);

	stream_credit_port stream_i (
		.clk(clk), .reset(reset),
		.push(push), .push_data(push_data),
		.clear_overflow(clear_overflow), .stream_credit(stream_credit),
		.stream_valid(stream_valid), .stream_data(stream_data),
		.credits(credits), .overflow(overflow)
	);

endmodule

/* verification/spi_reg_bridge_tb.sv */
`timescale 1ns/1ps

`include "spi_defines.svh"

module spi_reg_bridge_tb;
	import spi_link_pkg::*;
	import reg_map_pkg::*;

	// ========================================
	// timing and table types
	// ========================================

	localparam int CLK_PERIOD_NS = 4;
	localparam int SCK_PERIOD_NS = 32; // 8 clk per sck.
	localparam int HALF_CYCLES = SCK_PERIOD_NS / (2 * CLK_PERIOD_NS);

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CREDIT, OP_ABORT} op_t;

	// cont keeps cs low so the next row is the next byte of the burst.
	typedef struct packed {
		op_t op;
		logic cont;
		reg_addr_t addr; // address this byte lands on.
		spi_byte_t data; // mosi byte, or command byte for an abort.
		reg_data_t exp; // read data, or ctrl after a write transaction.
	} row_t;

	logic clk;
	logic reset;
	logic spi_sck;
	logic spi_mosi;
	logic spi_cs_n;
	logic spi_miso;
	reg_data_t status_in;
	reg_data_t ctrl;
	logic stream_credit;
	logic stream_valid;
	spi_byte_t stream_data;

	row_t rows[$];
	spi_byte_t exp_q[$]; // bytes that had a credit to spend.
	spi_byte_t got_q[$]; // bytes seen on the stream port.
	integer seed = 84709;
	integer rnd;
	int err_cnt = 0;
	int test_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	bit table_ready = 1'b0;

	spi_reg_bridge_top dut_i (
		.clk(clk), .reset(reset),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_cs_n(spi_cs_n),
		.spi_miso(spi_miso),
		.status_in(status_in), .ctrl(ctrl),
		.stream_credit(stream_credit), .stream_valid(stream_valid),
		.stream_data(stream_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD_NS / 2) clk = ~clk;
	end

	// ========================================
	// checks and reporting
	// ========================================

	task automatic check_byte(input string name, input spi_byte_t exp, input spi_byte_t got);
		if (got !== exp) begin
			$display("** Error: %s expected %h got %h", name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t got);
		if (got !== exp) begin
			$display("** Error: %s expected %h got %h", name, exp, got);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string label, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("test %0d %s: ok", test_cnt, label);
		end else begin
			fail_cnt++;
			$display("test %0d %s: FAILED", test_cnt, label);
		end
	endtask

	// ========================================
	// spi host model, mode 0
	// ========================================

	// called at a falling clk edge; mosi changes while sck is low.
	task automatic shift_byte(input spi_byte_t tx, input int nbits, output spi_byte_t rx);
		spi_byte_t sh;
		sh = tx;
		rx = '0;
		for (int n = 0; n < nbits; n++) begin
			spi_mosi = sh[7]; // msb first.
			repeat (HALF_CYCLES) @(negedge clk);
			spi_sck = 1'b1;
			rx = {rx[6:0], spi_miso}; // sampled at the rising edge.
			sh = {sh[6:0], 1'b0};
			repeat (HALF_CYCLES) @(negedge clk);
			spi_sck = 1'b0;
		end
	endtask

	task automatic start_txn();
		spi_cs_n = 1'b0; // first sck edge follows half a period later.
	endtask

	task automatic end_txn();
		repeat (HALF_CYCLES) @(negedge clk);
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		repeat (4 * HALF_CYCLES) @(negedge clk); // idle gap.
	endtask

	task automatic pulse_credit();
		stream_credit = 1'b1;
		@(negedge clk);
		stream_credit = 1'b0;
		repeat (HALF_CYCLES) @(negedge clk);
	endtask

	// ========================================
	// stimulus table
	// ========================================

	task automatic add_row(input op_t op, input logic cont, input reg_addr_t addr,
			input spi_byte_t data, input reg_data_t exp);
		row_t r;
		r.op = op;
		r.cont = cont;
		r.addr = addr;
		r.data = data;
		r.exp = exp;
		rows.push_back(r);
	endtask

	task automatic build_table(input reg_data_t status_val);
		add_row(OP_READ, 1'b0, ADDR_ID, 8'h00, 8'hA5);
		add_row(OP_WRITE, 1'b1, ADDR_SCRATCH, 8'h3C, 8'h00); // burst write.
		add_row(OP_WRITE, 1'b0, ADDR_CTRL, 8'hC3, 8'hC3);
		add_row(OP_READ, 1'b1, ADDR_SCRATCH, 8'h00, 8'h3C); // burst read.
		add_row(OP_READ, 1'b0, ADDR_CTRL, 8'h00, 8'hC3);
		add_row(OP_READ, 1'b0, ADDR_STATUS_IN, 8'h00, status_val);
		add_row(OP_WRITE, 1'b1, ADDR_STREAM, 8'h11, 8'h00); // spends all 4 credits.
		add_row(OP_WRITE, 1'b1, ADDR_STREAM, 8'h22, 8'h00);
		add_row(OP_WRITE, 1'b1, ADDR_STREAM, 8'h33, 8'h00);
		add_row(OP_WRITE, 1'b0, ADDR_STREAM, 8'h44, 8'hC3);
		add_row(OP_READ, 1'b0, ADDR_STATUS, 8'h00, 8'h00); // no credits left.
		add_row(OP_WRITE, 1'b0, ADDR_STREAM, 8'h55, 8'hC3); // dropped.
		add_row(OP_READ, 1'b0, ADDR_STATUS, 8'h00, 8'h01); // overflow set.
		add_row(OP_CREDIT, 1'b0, ADDR_ID, 8'h00, 8'h00);
		add_row(OP_CREDIT, 1'b0, ADDR_ID, 8'h00, 8'h00);
		add_row(OP_READ, 1'b0, ADDR_STATUS, 8'h00, 8'h21);
		add_row(OP_WRITE, 1'b0, ADDR_STATUS, 8'h01, 8'hC3); // w1c overflow.
		add_row(OP_READ, 1'b0, ADDR_STATUS, 8'h00, 8'h20);
		add_row(OP_WRITE, 1'b0, ADDR_STREAM, 8'h66, 8'hC3);
		add_row(OP_READ, 1'b0, ADDR_STATUS, 8'h00, 8'h10);
		add_row(OP_ABORT, 1'b0, ADDR_ID, 8'hAA, 8'h00); // 5 bits then cs high.
		add_row(OP_READ, 1'b0, ADDR_SCRATCH, 8'h00, 8'h3C);
	endtask

	// stream monitor samples mid-cycle.
	always @(negedge clk) begin
		if (!reset && stream_valid)
			got_q.push_back(stream_data);
	end

	// watchdog sized from the table.
	initial begin
		wait (table_ready);
		#(rows.size() * 20 * SCK_PERIOD_NS);
		$display("watchdog expired before the table finished");
		$display("tests failed");
		$finish;
	end

	// ========================================
	// main sequence
	// ========================================

	initial begin
		row_t r;
		op_t op;
		spi_byte_t cmd;
		spi_byte_t rx;
		int errs_before;
		bit in_txn;
		int model_credits;

		reset = 1'b1;
		spi_sck = 1'b0;
		spi_mosi = 1'b0;
		spi_cs_n = 1'b1;
		stream_credit = 1'b0;
		rnd = $random(seed);
		status_in = rnd[7:0];
		in_txn = 1'b0;
		model_credits = `STREAM_CREDITS;
		build_table(status_in);
		table_ready = 1'b1;

		repeat (4) @(negedge clk);
		reset = 1'b0;
		errs_before = err_cnt;
		check_reg("ctrl", 8'h00, ctrl);
		report_test("reset", errs_before);

		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			op = r.op;
			errs_before = err_cnt;
			case (op)
				OP_WRITE, OP_READ: begin
					if (!in_txn) begin
						start_txn();
						cmd = {op == OP_READ, 3'b000, r.addr}; // bit 7 selects read.
						shift_byte(cmd, 8, rx);
						in_txn = 1'b1;
					end
					shift_byte(r.data, 8, rx);
					if (op == OP_READ)
						check_byte("spi_miso", r.exp, rx);
					if (op == OP_WRITE && r.addr == ADDR_STREAM && model_credits > 0) begin
						exp_q.push_back(r.data); // only paid-for bytes leave.
						model_credits--;
					end
					if (!r.cont) begin
						end_txn();
						in_txn = 1'b0;
						if (op == OP_WRITE)
							check_reg("ctrl", r.exp, ctrl);
					end
				end
				OP_CREDIT: begin
					pulse_credit();
					if (model_credits < `STREAM_CREDITS)
						model_credits++;
				end
				default: begin // abort.
					start_txn();
					shift_byte(r.data, 5, rx);
					end_txn();
				end
			endcase
			report_test($sformatf("%s addr %0h", op.name(), r.addr), errs_before);
		end

		// stream bytes in push order.
		errs_before = err_cnt;
		if (got_q.size() != exp_q.size()) begin
			$display("stream port sent %0d bytes where %0d were expected",
				got_q.size(), exp_q.size());
			err_cnt++;
		end else begin
			for (int k = 0; k < exp_q.size(); k++)
				check_byte("stream_data", exp_q[k], got_q[k]);
		end
		report_test("stream order", errs_before);

		$display("%0d run, %0d passed, %0d failing, %0d errors",
			test_cnt, pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+common
common/spi_link_pkg.sv
common/reg_map_pkg.sv
spi_device/spi_device_transceiver.sv
spi_device/spi_command_decoder.sv
hw/reg_bank.sv
hw/stream_credit_port.sv
hw/spi_reg_bridge_top.sv
verification/spi_reg_bridge_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = spi_reg_bridge_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# run it, then decide pass or fail from the log
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation result: PASS"; \
	else \
		echo "simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
